// File: Bender.yml
package:
  name: dcp_dump

dependencies: {}

sources:
  - files:
      - dcp_pkg.sv
      - dcp_dump_fsm.sv
      - dcp_line_counter.sv
      - dcp_dump_datapath.sv
      - dcp_dump_top.sv
  - target: test
    files:
      - tb_dcp_dump.sv

export_include_dirs: []

// File: all.f
dcp_pkg.sv
dcp_dump_fsm.sv
dcp_line_counter.sv
dcp_dump_datapath.sv
dcp_dump_top.sv
tb_dcp_dump.sv

// File: dcp_dump_datapath.sv
`timescale 1ns/1ps

module dcp_dump_datapath (
    input  logic               clk,
    input  logic               reset,
    input  dcp_pkg::char_pos_t pos,
    input  logic               scan_load,
    input  logic               word_load,
    input  logic               line_done,
    input  dcp_pkg::addr_t     din_rx,
    input  dcp_pkg::word_t     dout_dm,
    output dcp_pkg::addr_t     addr,
    output dcp_pkg::char_t     dout
);

    dcp_pkg::addr_t base;        // Line start, kept between dumps
    dcp_pkg::word_t word;        // Word being printed
    logic [2:0]     word_idx;    // Word of the current or upcoming field
    logic [2:0]     nib_idx;     // Nibble index with 7 most significant
    dcp_pkg::word_t nib_src;     // Address or data being printed
    logic [3:0]     nibble;

    function automatic dcp_pkg::char_t hex_char(input logic [3:0] n);
        dcp_pkg::char_t c;
        if (n < 4'd10) begin
            c = dcp_pkg::CHAR_ZERO + dcp_pkg::char_t'(n);
        end else begin
            c = dcp_pkg::CHAR_A + dcp_pkg::char_t'(n - 4'd10);
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            base <= '0;
        end else if (scan_load) begin
            base <= {din_rx[31:2], 2'b00};                    // Force word alignment
        end else if (line_done) begin
            base <= base + dcp_pkg::LINE_STRIDE;               // Continue after this line
        end
    end

    always_ff @(posedge clk) begin
        if (word_load) begin
            word <= dout_dm;
        end
    end

    // Memory address for the word field in progress
    always_comb begin
        if (pos.field == dcp_pkg::FIELD_ADDR) begin
            word_idx = 3'd0;                                   // First word comes next
        end else if (pos.field > dcp_pkg::field_t'(dcp_pkg::WORDS_PER_LINE)) begin
            word_idx = 3'(dcp_pkg::WORDS_PER_LINE - 1);         // Line end keeps last word
        end else begin
            word_idx = 3'(pos.field - 4'd1);
        end
    end

    assign addr = base + {27'd0, word_idx, 2'b00};

    // Digit 1 is the top nibble
    assign nib_idx = 3'(dcp_pkg::POS_LAST - pos.pos);
    assign nib_src = (pos.field == dcp_pkg::FIELD_ADDR) ? base : word;
    assign nibble  = 4'(nib_src >> {nib_idx, 2'b00});

    always_comb begin
        if (pos.field == dcp_pkg::FIELD_END) begin
            dout = (pos.pos == dcp_pkg::POS_LF) ? dcp_pkg::CHAR_LF : dcp_pkg::CHAR_CR;
        end else if (pos.pos == dcp_pkg::POS_PREFIX) begin
            // '@' before the address, a space before each word
            dout = (pos.field == dcp_pkg::FIELD_ADDR) ? dcp_pkg::CHAR_AT
                                                      : dcp_pkg::CHAR_SPACE;
        end else begin
            dout = hex_char(nibble);
        end
    end

    // Base alignment must survive scan loads and line strides
    a_addr_aligned: assert property (
        @(posedge clk) disable iff (reset)
        addr[1:0] == 2'b00
    );

endmodule

// File: dcp_dump_fsm.sv
`timescale 1ns/1ps

module dcp_dump_fsm (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  dcp_pkg::char_t     cmd,
    input  logic               ack_rx,
    input  logic               flag_rx,
    input  logic               ack_tx,
    input  logic               field_end,
    input  logic               line_end,
    input  logic               next_is_word,
    output logic               req_rx,
    output logic               req_tx,
    output logic               finish,
    output logic               clear,
    output logic               advance,
    output logic               scan_load,
    output logic               word_load,
    output logic               line_done
);

    dcp_pkg::dump_state_t state;       // Current step
    dcp_pkg::dump_state_t state_next;  // Step after this cycle
    logic                 cmd_hit;     // Accepted dump command

    assign cmd_hit = start && (cmd == dcp_pkg::CMD_DUMP);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcp_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;                                    // Hold by default
        case (state)
            dcp_pkg::IDLE: begin
                if (cmd_hit) begin
                    state_next = dcp_pkg::SCAN;
                end
            end
            dcp_pkg::SCAN: begin
                if (ack_rx) begin
                    state_next = dcp_pkg::SEND;                // '@' goes out next
                end
            end
            dcp_pkg::SEND: begin
                if (ack_tx) begin
                    state_next = line_end ? dcp_pkg::DONE : dcp_pkg::GAP;
                end
            end
            dcp_pkg::GAP: begin
                // Counter still shows the character just sent
                if (field_end && next_is_word) begin
                    state_next = dcp_pkg::FETCH;
                end else begin
                    state_next = dcp_pkg::SEND;
                end
            end
            dcp_pkg::FETCH: state_next = dcp_pkg::LOAD;        // Memory latency
            dcp_pkg::LOAD:  state_next = dcp_pkg::SEND;
            dcp_pkg::DONE:  state_next = dcp_pkg::IDLE;
            default:        state_next = dcp_pkg::IDLE;
        endcase
    end

    // Requests are plain state decodes
    assign req_rx    = (state == dcp_pkg::SCAN);
    assign req_tx    = (state == dcp_pkg::SEND);
    assign finish    = (state == dcp_pkg::DONE);

    assign clear     = (state == dcp_pkg::IDLE) && cmd_hit;    // New line from field 0
    assign advance   = (state == dcp_pkg::GAP);                // One step per character
    assign scan_load = req_rx && ack_rx && !flag_rx;           // Typed address only
    assign word_load = (state == dcp_pkg::LOAD);
    assign line_done = finish;                                 // Base moves on with finish

    // Scanner and transmitter are never asked at the same time
    a_req_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(req_rx && req_tx)
    );

    a_finish_single: assert property (
        @(posedge clk) disable iff (reset)
        finish |=> !finish
    );

    // Character is withdrawn only after the transmitter took it
    a_req_tx_held: assert property (
        @(posedge clk) disable iff (reset)
        (req_tx && !ack_tx) |=> req_tx
    );

endmodule

// File: dcp_dump_top.sv
`timescale 1ns/1ps

module dcp_dump_top (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,        // Command decoder strobe
    input  dcp_pkg::char_t cmd,
    output logic           req_rx,       // Scanner handshake
    input  logic           ack_rx,
    input  logic           flag_rx,      // High when nothing was typed
    input  dcp_pkg::addr_t din_rx,
    output dcp_pkg::addr_t addr,         // Data memory read port
    input  dcp_pkg::word_t dout_dm,
    output logic           req_tx,       // Transmitter handshake
    output dcp_pkg::char_t dout,
    input  logic           ack_tx,
    output logic           finish
);

    logic               clear;           // Counter back to '@'
    logic               advance;
    dcp_pkg::char_pos_t pos;
    logic               field_end;
    logic               line_end;
    logic               next_is_word;
    logic               scan_load;       // Typed address into base
    logic               word_load;       // Memory word into print register
    logic               line_done;

    dcp_dump_fsm i_fsm (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .cmd          (cmd),
        .ack_rx       (ack_rx),
        .flag_rx      (flag_rx),
        .ack_tx       (ack_tx),
        .field_end    (field_end),
        .line_end     (line_end),
        .next_is_word (next_is_word),
        .req_rx       (req_rx),
        .req_tx       (req_tx),
        .finish       (finish),
        .clear        (clear),
        .advance      (advance),
        .scan_load    (scan_load),
        .word_load    (word_load),
        .line_done    (line_done)
    );

    dcp_line_counter i_counter (
        .clk          (clk),
        .reset        (reset),
        .clear        (clear),
        .advance      (advance),
        .pos          (pos),
        .field_end    (field_end),
        .line_end     (line_end),
        .next_is_word (next_is_word)
    );

    dcp_dump_datapath i_datapath (
        .clk          (clk),
        .reset        (reset),
        .pos          (pos),
        .scan_load    (scan_load),
        .word_load    (word_load),
        .line_done    (line_done),
        .din_rx       (din_rx),
        .dout_dm      (dout_dm),
        .addr         (addr),
        .dout         (dout)
    );

endmodule

// File: dcp_line_counter.sv
`timescale 1ns/1ps

module dcp_line_counter (
    input  logic               clk,
    input  logic               reset,
    input  logic               clear,
    input  logic               advance,
    output dcp_pkg::char_pos_t pos,
    output logic               field_end,
    output logic               line_end,
    output logic               next_is_word
);

    logic in_end_field;  // CR LF field

    assign in_end_field = (pos.field == dcp_pkg::FIELD_END);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            pos.field <= dcp_pkg::FIELD_ADDR;
            pos.pos   <= dcp_pkg::POS_PREFIX;
        end else if (advance) begin
            if (in_end_field) begin
                if (pos.pos != dcp_pkg::POS_LF) begin
                    pos.pos <= pos.pos + 4'd1;                // CR to LF, then stop
                end
            end else if (pos.pos == dcp_pkg::POS_LAST) begin
                pos.field <= pos.field + 4'd1;                // Wrap into next field
                pos.pos   <= dcp_pkg::POS_PREFIX;
            end else begin
                pos.pos <= pos.pos + 4'd1;
            end
        end
    end

    // Flags decoded from the count
    assign line_end     = in_end_field && (pos.pos == dcp_pkg::POS_LF);
    assign field_end    = in_end_field ? line_end : (pos.pos == dcp_pkg::POS_LAST);
    assign next_is_word = (pos.field < dcp_pkg::field_t'(dcp_pkg::WORDS_PER_LINE));

    a_pos_legal: assert property (
        @(posedge clk) disable iff (reset)
        (pos.field <= dcp_pkg::FIELD_END) &&
        (in_end_field ? (pos.pos <= dcp_pkg::POS_LF) : (pos.pos <= dcp_pkg::POS_LAST))
    );

endmodule

// File: dcp_pkg.sv
package dcp_pkg;

    // Bus and character widths
    typedef logic [31:0] addr_t;                 // Data memory byte address
    typedef logic [31:0] word_t;                 // Data memory word
    typedef logic [7:0]  char_t;                 // ASCII character or command byte
    typedef logic [3:0]  field_t;                // Field index within the dump line

    // Line layout
    localparam char_t CMD_DUMP         = 8'h44;  // 'D'
    localparam int    WORDS_PER_LINE   = 8;      // Data words per line
    localparam int    NIBBLES_PER_WORD = 8;      // Hex digits per field
    localparam addr_t LINE_STRIDE      = 32'd32; // Base step after each dump

    localparam field_t FIELD_ADDR = 4'd0;                       // Address field
    localparam field_t FIELD_END  = 4'(WORDS_PER_LINE + 1);     // CR LF field
    localparam logic [3:0] POS_PREFIX = 4'd0;                   // Prefix slot
    localparam logic [3:0] POS_LAST   = 4'(NIBBLES_PER_WORD);   // Last hex digit
    localparam logic [3:0] POS_LF     = 4'd1;                   // LF slot in end field

    // Characters
    localparam char_t CHAR_AT    = 8'h40;        // '@'
    localparam char_t CHAR_SPACE = 8'h20;        // ' '
    localparam char_t CHAR_CR    = 8'h0d;
    localparam char_t CHAR_LF    = 8'h0a;
    localparam char_t CHAR_ZERO  = 8'h30;        // '0'
    localparam char_t CHAR_A     = 8'h41;        // 'A' for upper case hex digits

    // Position of the character being sent
    typedef struct packed {
        field_t     field;                       // 0 address, 1..8 words, 9 line end
        logic [3:0] pos;                         // 0 prefix, 1..8 digits MSB first
    } char_pos_t;

    // Dump sequencer states
    typedef enum logic [2:0] {
        IDLE,                                    // Waiting for a 'D' command
        SCAN,                                    // Address requested from scanner
        FETCH,                                   // Word address on the memory bus
        LOAD,                                    // Memory data captured
        SEND,                                    // Character held for transmitter
        GAP,                                     // Request low, counter steps
        DONE                                     // Finish pulse
    } dump_state_t;

endpackage

// File: dump_tests.txt
// Columns in hex: command byte, flag_rx (1 = nothing typed), scanned address,
// largest acknowledge delay in cycles
44 1 00000000 0
44 1 12345678 2
44 0 00001000 0
44 0 00002003 3
44 1 00000000 1
41 0 00000500 2
44 1 00000000 4
64 0 00003000 1
44 0 7ffffff1 2
44 1 00000000 0
44 0 fffffffe 3
44 1 00000000 5
44 0 a5a5c3c2 1

// File: tb_dcp_dump.sv
`timescale 1ns/1ps

module tb_dcp_dump;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 16;
    localparam int          LINE_CHARS   = 83;    // '@' + 8 digits, 8 x (space + 8), CR LF
    localparam int          MAX_TESTS    = 64;
    localparam int          REQ_TIMEOUT  = 64;    // Cycles allowed for a request to show up
    localparam int          IDLE_CHECK   = 20;    // Cycles watched after an ignored command
    localparam logic [7:0]  CMD_D        = "D";
    localparam logic [31:0] STRIDE       = 32'd32;

    logic           clk;
    logic           reset;
    logic           start;
    dcp_pkg::char_t cmd;
    logic           req_rx;
    logic           ack_rx;
    logic           flag_rx;
    dcp_pkg::addr_t din_rx;
    dcp_pkg::addr_t addr;
    dcp_pkg::word_t dout_dm;
    logic           req_tx;
    dcp_pkg::char_t dout;
    logic           ack_tx;
    logic           finish;

    logic [31:0]    tests [0:4*MAX_TESTS-1];    // cmd, flag_rx, address, delay limit
    int             num_tests;
    int             max_delay;
    int             watchdog_cycles;
    bit             tests_loaded;
    int             cur_test;
    int             errors;
    int             chars_checked;
    dcp_pkg::addr_t model_base;                 // Base the DUT should be holding
    dcp_pkg::addr_t addr_seen;                  // Memory address of the previous cycle
    logic [7:0]     exp_line [0:LINE_CHARS-1];

    dcp_dump_top i_dut (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .cmd     (cmd),
        .req_rx  (req_rx),
        .ack_rx  (ack_rx),
        .flag_rx (flag_rx),
        .din_rx  (din_rx),
        .addr    (addr),
        .dout_dm (dout_dm),
        .req_tx  (req_tx),
        .dout    (dout),
        .ack_tx  (ack_tx),
        .finish  (finish)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Memory content is the upper address half and the inverted lower half
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:16], ~a[15:0]};
    endfunction

    function automatic logic [7:0] hex_digit(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + n : 8'h37 + n;   // Upper-case letters
    endfunction

    // Data memory with one cycle of registered latency
    initial begin
        dout_dm   = '0;
        addr_seen = '0;
        forever begin
            @(negedge clk);
            dout_dm   = mem_word(addr_seen);
            addr_seen = addr;
        end
    end

    task automatic put_hex(input logic [31:0] value, inout int idx);
        for (int d = 7; d >= 0; d--) begin
            exp_line[idx] = hex_digit(value[4*d +: 4]);  // MSB first
            idx++;
        end
    endtask

    task automatic build_line(input logic [31:0] base);
        int idx;
        idx = 0;
        exp_line[idx] = "@";
        idx++;
        put_hex(base, idx);
        for (int k = 0; k < 8; k++) begin
            exp_line[idx] = " ";
            idx++;
            put_hex(mem_word(base + 32'(4 * k)), idx);
        end
        exp_line[idx]     = 8'h0d;                  // CR
        exp_line[idx + 1] = 8'h0a;                  // LF
    endtask

    task automatic wait_req_rx(output bit seen);
        int n;
        n = 0;
        while (!req_rx && n < REQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        seen = req_rx;
    endtask

    task automatic wait_req_tx(output bit seen);
        int n;
        n = 0;
        while (!req_tx && n < REQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        seen = req_tx;
    endtask

    task automatic wait_finish(output bit seen);
        int n;
        n = 0;
        while (!finish && n < REQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        seen = finish;
    endtask

    // Scanner answers the address request after a random delay
    task automatic answer_scan(input logic flag, input logic [31:0] value, input int limit);
        bit seen;
        int delay;
        wait_req_rx(seen);
        assert (seen) else begin
            errors++;
            $display("No scan request after dump command in test %0d", cur_test);
        end
        if (seen) begin
            delay = int'($urandom % (limit + 1));
            repeat (delay) @(negedge clk);
            ack_rx  = 1'b1;
            flag_rx = flag;
            din_rx  = value;
            @(negedge clk);
            ack_rx  = 1'b0;
            flag_rx = 1'b0;
            din_rx  = '0;
            assert (!req_rx) else begin
                errors++;
                $display("Scan request still high after acknowledge in test %0d", cur_test);
            end
        end
    endtask

    // Transmitter takes each byte after a random delay
    task automatic collect_line(input int limit);
        logic [7:0] held;
        bit         seen;
        bit         ok;
        int         delay;
        ok = 1'b1;
        for (int i = 0; i < LINE_CHARS && ok; i++) begin
            wait_req_tx(seen);
            assert (seen) else begin
                errors++;
                $display("No transmit request for character %0d of test %0d", i, cur_test);
            end
            ok = seen;
            if (ok) begin
                held  = dout;
                delay = int'($urandom % (limit + 1));
                repeat (delay) begin
                    @(negedge clk);
                    assert (req_tx) else begin
                        errors++;
                        $display("Transmit request dropped without acknowledge at index %0d",
                                 i);
                    end
                    assert (dout == held) else begin
                        errors++;
                        $display("Fail dout held %h changed to %h at index %0d", held, dout, i);
                    end
                end
                chars_checked++;
                assert (dout == exp_line[i]) else begin
                    errors++;
                    $display("Fail dout index %0d expected %h got %h", i, exp_line[i], dout);
                end
                ack_tx = 1'b1;
                @(negedge clk);
                ack_tx = 1'b0;
            end
        end
    endtask

    task automatic check_finish();
        bit seen;
        wait_finish(seen);
        assert (seen) else begin
            errors++;
            $display("No finish pulse after the line in test %0d", cur_test);
        end
        if (seen) begin
            @(negedge clk);
            assert (!finish) else begin
                errors++;
                $display("Finish lasted more than one cycle in test %0d", cur_test);
            end
        end
    endtask

    task automatic check_ignored(input logic [7:0] c);
        repeat (IDLE_CHECK) begin
            @(negedge clk);
            assert (!req_rx && !req_tx && !finish) else begin
                errors++;
                $display("Command %h was not ignored in test %0d", c, cur_test);
            end
        end
    endtask

    initial begin : stimulus
        int unsigned seed_val;
        logic [7:0]  t_cmd;
        logic        t_flag;
        logic [31:0] t_addr;
        int          t_limit;
        seed_val = $urandom(32'hcf5c);
        reset    = 1'b1;
        start    = 1'b0;
        cmd      = '0;
        ack_rx   = 1'b0;
        flag_rx  = 1'b0;
        din_rx   = '0;
        ack_tx   = 1'b0;
        errors        = 0;
        chars_checked = 0;
        model_base    = '0;                         // DUT base after reset
        for (int i = 0; i < 4 * MAX_TESTS; i++) begin
            tests[i] = {16'hffff, 16'(i)};          // Above any command byte to mark the end
        end
        $readmemh("dump_tests.txt", tests);
        num_tests = 0;
        max_delay = 0;
        while (num_tests < MAX_TESTS && tests[4 * num_tests][31:8] == '0) begin
            if (int'(tests[4 * num_tests + 3]) > max_delay) begin
                max_delay = int'(tests[4 * num_tests + 3]);
            end
            num_tests++;
        end
        assert (num_tests > 0) else begin
            errors++;
            $display("No tests found in dump_tests.txt");
        end
        watchdog_cycles = RESET_CYCLES + 1000 +
                          num_tests * (LINE_CHARS * (max_delay + 5) + 4 * REQ_TIMEOUT);
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (!req_rx && !req_tx && !finish) else begin
            errors++;
            $display("Request or finish active right after reset");
        end
        for (int t = 0; t < num_tests; t++) begin
            cur_test = t;
            t_cmd    = tests[4 * t][7:0];
            t_flag   = tests[4 * t + 1][0];
            t_addr   = tests[4 * t + 2];
            t_limit  = int'(tests[4 * t + 3]);
            start = 1'b1;
            cmd   = t_cmd;
            @(negedge clk);
            start = 1'b0;
            if (t_cmd == CMD_D) begin
                if (!t_flag) begin
                    model_base = {t_addr[31:2], 2'b00};   // Typed address made word aligned
                end
                build_line(model_base);
                answer_scan(t_flag, t_addr, t_limit);
                collect_line(t_limit);
                check_finish();
                model_base = model_base + STRIDE;         // Next dump continues here
            end else begin
                check_ignored(t_cmd);
            end
            @(negedge clk);
        end
        $display("%0d tests, %0d characters checked, %0d errors",
                 num_tests, chars_checked, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Limit scales with line length and the slowest acknowledge
    initial begin : watchdog
        wait (tests_loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the dump sequence did not complete", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule
